// ==== hw/lsuPkg.sv ====
package lsuPkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int TAG_W     = 4;
    localparam int LSB_DEPTH = 4;
    localparam int RAM_AW    = 10;                      // 1024 bytes, wraps
    localparam int LEN_W     = 3;                       // 1..4 bytes
    localparam int PTR_W     = $clog2(LSB_DEPTH);
    localparam int CNT_W     = $clog2(LSB_DEPTH + 1);

    // bit 3 marks a store, bit 2 unsigned load, bits 1:0 log2 of the size
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsOp_t;

    typedef enum logic [1:0] {
        IDLE,
        XFER,
        DONE
    } memState_t;

    function automatic logic isStore(input lsOp_t op);
        return op[3];
    endfunction

    function automatic logic [LEN_W-1:0] opLen(input lsOp_t op);
        return LEN_W'(1) << op[1:0];                    // 1, 2 or 4
    endfunction

endpackage

// ==== hw/dataRam.sv ====
`timescale 1ns/1ns

module dataRam import lsuPkg::*; (
    input  logic              clk,
    input  logic              ramEn,
    input  logic              ramWe,
    input  logic [RAM_AW-1:0] ramAddr,
    input  logic [7:0]        ramWdata,
    output logic [7:0]        ramRdata
);

    logic [7:0] mem [2**RAM_AW];

    // single port, registered read
    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[ramAddr] <= ramWdata;
            end else begin
                ramRdata <= mem[ramAddr];   // valid next cycle
            end
        end
    end

endmodule

// ==== hw/memCtrl.sv ====
`timescale 1ns/1ns

module memCtrl import lsuPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              memWrite,
    input  logic [ADDR_W-1:0] memAddr,
    input  logic [LEN_W-1:0]  memLen,
    input  logic [DATA_W-1:0] memWdata,
    output logic              memDone,
    output logic [DATA_W-1:0] memRdata,
    output logic              ramEn,
    output logic              ramWe,
    output logic [RAM_AW-1:0] ramAddr,
    output logic [7:0]        ramWdata,
    input  logic [7:0]        ramRdata
);

    memState_t         state;
    logic [LEN_W-1:0]  cnt;
    logic [LEN_W-1:0]  len;
    logic [RAM_AW-1:0] baseAddr;    // upper address bits wrap away
    logic [DATA_W-1:0] wdata;
    logic              wrFlag;
    logic [DATA_W-1:0] rdBuf;
    logic              rdPend;      // ram byte due this cycle
    logic [1:0]        rdIdx;

    // **************************************************
    // byte lane to the RAM
    // **************************************************
    assign ramEn    = (state == XFER);
    assign ramWe    = (state == XFER) && wrFlag;
    assign ramAddr  = baseAddr + RAM_AW'(cnt);
    assign ramWdata = wdata[{cnt[1:0], 3'b000} +: 8];   // low byte first
    assign memDone  = (state == DONE);

    // last byte lands in the DONE cycle itself
    always_comb begin
        memRdata = rdBuf;
        if (rdPend) memRdata[{rdIdx, 3'b000} +: 8] = ramRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            cnt    <= '0;
            rdPend <= 1'b0;
        end else begin
            rdPend <= (state == XFER) && !wrFlag;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start) state <= XFER;
                end
                XFER: begin
                    cnt <= cnt + LEN_W'(1);
                    if (cnt == len - LEN_W'(1)) state <= DONE;
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rdIdx <= cnt[1:0];
        if (start && state == IDLE) begin
            len      <= memLen;
            baseAddr <= memAddr[RAM_AW-1:0];
            wdata    <= memWdata;
            wrFlag   <= memWrite;
            rdBuf    <= '0;                 // unread upper bytes
        end else if (rdPend) begin
            rdBuf[{rdIdx, 3'b000} +: 8] <= ramRdata;
        end
    end

    startInIdle: assert property (@(posedge clk) disable iff (rst)
        start |-> state == IDLE)
        else $error("start while controller busy");

endmodule

// ==== hw/loadStoreBuffer.sv ====
`timescale 1ns/1ns

module loadStoreBuffer import lsuPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  logic              reqValid,
    input  lsOp_t             reqOp,
    input  logic [ADDR_W-1:0] reqAddr,
    input  logic [DATA_W-1:0] reqData,
    input  logic [TAG_W-1:0]  reqTag,
    output logic              reqReady,
    output logic              issueValid,
    output lsOp_t             issueOp,
    output logic [ADDR_W-1:0] issueAddr,
    output logic [DATA_W-1:0] issueData,
    output logic [TAG_W-1:0]  issueTag,
    input  logic              issueReady
);

    lsOp_t             opMem   [LSB_DEPTH];
    logic [ADDR_W-1:0] addrMem [LSB_DEPTH];
    logic [DATA_W-1:0] dataMem [LSB_DEPTH];
    logic [TAG_W-1:0]  tagMem  [LSB_DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(LSB_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign reqReady   = (count != CNT_W'(LSB_DEPTH));
    assign issueValid = (count != '0);
    assign push       = reqValid && reqReady;
    assign pop        = issueValid && issueReady;

    // head entry straight out of the array
    assign issueOp   = opMem[rdPtr];
    assign issueAddr = addrMem[rdPtr];
    assign issueData = dataMem[rdPtr];
    assign issueTag  = tagMem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            opMem[wrPtr]   <= reqOp;
            addrMem[wrPtr] <= reqAddr;
            dataMem[wrPtr] <= reqData;
            tagMem[wrPtr]  <= reqTag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;        // both or neither
            endcase
        end
    end

    countBound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(LSB_DEPTH))
        else $error("load/store buffer count above depth");

endmodule

// ==== hw/dataAccess.sv ====
`timescale 1ns/1ns

module dataAccess import lsuPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  logic              issueValid,
    input  lsOp_t             issueOp,
    input  logic [ADDR_W-1:0] issueAddr,
    input  logic [DATA_W-1:0] issueData,
    input  logic [TAG_W-1:0]  issueTag,
    output logic              issueReady,
    output logic              start,
    output logic              memWrite,
    output logic [ADDR_W-1:0] memAddr,
    output logic [LEN_W-1:0]  memLen,
    output logic [DATA_W-1:0] memWdata,
    input  logic              memDone,
    input  logic [DATA_W-1:0] memRdata,
    output logic              respValid,
    output logic [DATA_W-1:0] respData,
    output logic [TAG_W-1:0]  respTag,
    input  logic              respReady
);

    logic              occupied;
    logic              issued;      // our access is in the controller
    logic              memBusy;     // controller busy, survives clr
    lsOp_t             op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [TAG_W-1:0]  tag;
    logic              ownDone;
    logic [DATA_W-1:0] extData;

    assign issueReady = !occupied;
    assign start      = occupied && !issued && !memBusy && !respValid;
    assign memWrite   = isStore(op);
    assign memLen     = opLen(op);
    assign memAddr    = addr;
    assign memWdata   = wdata;
    assign respTag    = tag;
    assign ownDone    = memDone && issued;  // stale done after clr is dropped

    always_comb begin
        case (op)
            LB:      extData = {{(DATA_W-8){memRdata[7]}}, memRdata[7:0]};
            LH:      extData = {{(DATA_W-16){memRdata[15]}}, memRdata[15:0]};
            LBU:     extData = {{(DATA_W-8){1'b0}}, memRdata[7:0]};
            LHU:     extData = {{(DATA_W-16){1'b0}}, memRdata[15:0]};
            LW:      extData = memRdata;
            default: extData = '0;              // stores
        endcase
    end

    always_ff @(posedge clk) begin
        if (issueValid && issueReady) begin
            op    <= issueOp;
            addr  <= issueAddr;
            wdata <= issueData;
            tag   <= issueTag;
        end
        if (ownDone) respData <= extData;
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            occupied  <= 1'b0;
            issued    <= 1'b0;
            respValid <= 1'b0;
        end else begin
            if (issueValid && issueReady) occupied <= 1'b1;
            if (start) issued <= 1'b1;
            if (ownDone) begin
                issued    <= 1'b0;
                respValid <= 1'b1;
            end
            if (respValid && respReady) begin
                respValid <= 1'b0;
                occupied  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) memBusy <= 1'b0;
        else if (start) memBusy <= 1'b1;
        else if (memDone) memBusy <= 1'b0;
    end

    respStable: assert property (@(posedge clk) disable iff (rst || clr)
        respValid && !respReady |=> respValid && $stable(respData))
        else $error("response changed while stalled");

endmodule

// ==== hw/lsuTop.sv ====
`timescale 1ns/1ns

module lsuTop import lsuPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  logic              reqValid,
    input  lsOp_t             reqOp,
    input  logic [ADDR_W-1:0] reqAddr,
    input  logic [DATA_W-1:0] reqData,
    input  logic [TAG_W-1:0]  reqTag,
    output logic              reqReady,
    output logic              respValid,
    output logic [DATA_W-1:0] respData,
    output logic [TAG_W-1:0]  respTag,
    input  logic              respReady
);

    // **************************************************
    // buffer to access unit
    // **************************************************
    logic              issueValid;
    logic              issueReady;
    lsOp_t             issueOp;
    logic [ADDR_W-1:0] issueAddr;
    logic [DATA_W-1:0] issueData;
    logic [TAG_W-1:0]  issueTag;

    // **************************************************
    // access unit to controller to RAM
    // **************************************************
    logic              start;
    logic              memWrite;
    logic [ADDR_W-1:0] memAddr;
    logic [LEN_W-1:0]  memLen;
    logic [DATA_W-1:0] memWdata;
    logic              memDone;
    logic [DATA_W-1:0] memRdata;
    logic              ramEn;
    logic              ramWe;
    logic [RAM_AW-1:0] ramAddr;
    logic [7:0]        ramWdata;
    logic [7:0]        ramRdata;

    loadStoreBuffer uBuffer (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .reqValid   (reqValid),
        .reqOp      (reqOp),
        .reqAddr    (reqAddr),
        .reqData    (reqData),
        .reqTag     (reqTag),
        .reqReady   (reqReady),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueAddr  (issueAddr),
        .issueData  (issueData),
        .issueTag   (issueTag),
        .issueReady (issueReady)
    );

    dataAccess uAccess (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueAddr  (issueAddr),
        .issueData  (issueData),
        .issueTag   (issueTag),
        .issueReady (issueReady),
        .start      (start),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memLen     (memLen),
        .memWdata   (memWdata),
        .memDone    (memDone),
        .memRdata   (memRdata),
        .respValid  (respValid),
        .respData   (respData),
        .respTag    (respTag),
        .respReady  (respReady)
    );

    memCtrl uMemCtrl (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memLen   (memLen),
        .memWdata (memWdata),
        .memDone  (memDone),
        .memRdata (memRdata),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    dataRam uRam (
        .clk      (clk),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

// ==== testbench/lsuChecker.sv ====
`timescale 1ns/1ns

module lsuChecker import lsuPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  logic              reqReady,
    input  logic              respValid,
    input  logic              respReady,
    input  logic [DATA_W-1:0] respData,
    input  logic [TAG_W-1:0]  respTag,
    output int                respCount,
    output int                mismatchCount,
    output int                protocolCount,
    output int                expectedTotal,
    output logic              sawFull
);

    logic [DATA_W-1:0] expData [$];
    logic [TAG_W-1:0]  expTag  [$];
    lsOp_t             expOp   [$];
    logic              stalled;
    logic [DATA_W-1:0] heldData;
    logic [TAG_W-1:0]  heldTag;

    // **************************************************
    // expected responses, in request order
    // **************************************************
    initial begin : loadTrace
        int                fd;
        int                n;
        logic [8*160-1:0]  line;
        logic [31:0]       kind;
        logic [31:0]       op;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [31:0]       tag;
        logic [31:0]       expVal;
        logic [31:0]       flag;
        expectedTotal = 0;
        fd = $fopen("testbench/lsuTrace.txt", "r");
        if (fd == 0) begin
            $display("checker could not open the trace file");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                kind, op, addr, data, tag, expVal, flag);
                    if (n == 7 && kind == 0 && flag[0]) begin
                        expData.push_back(expVal);
                        expTag.push_back(tag[TAG_W-1:0]);
                        expOp.push_back(lsOp_t'(op[3:0]));
                    end
                end
            end
            $fclose(fd);
            expectedTotal = expData.size();
        end
    end

    always @(posedge clk) begin : watch
        lsOp_t curOp;
        string testName;
        if (rst) begin
            respCount     = 0;
            mismatchCount = 0;
            protocolCount = 0;
            stalled      <= 1'b0;
            sawFull      <= 1'b0;
        end else begin
            // held response must not move
            if (stalled && (!respValid || respData != heldData || respTag != heldTag)) begin
                protocolCount = protocolCount + 1;
                $display("Error stall expected %h actual %h", heldData, respData);
            end
            stalled  <= respValid && !respReady && !clr;
            heldData <= respData;
            heldTag  <= respTag;
            if (!reqReady) sawFull <= 1'b1;
            if (respValid && respReady) begin
                respCount = respCount + 1;
                if (expData.size() == 0) begin
                    protocolCount = protocolCount + 1;
                    $display("unexpected response with tag %h and data %h", respTag, respData);
                end else begin
                    curOp    = expOp[0];
                    testName = $sformatf("%s_tag%0h", curOp.name(), expTag[0]);
                    if (respTag != expTag[0]) begin
                        mismatchCount = mismatchCount + 1;
                        $display("Error %s tag expected %h actual %h",
                                 testName, expTag[0], respTag);
                    end
                    if (respData != expData[0]) begin
                        mismatchCount = mismatchCount + 1;
                        $display("Error %s data expected %h actual %h",
                                 testName, expData[0], respData);
                    end
                    void'(expData.pop_front());
                    void'(expTag.pop_front());
                    void'(expOp.pop_front());
                end
            end
        end
    end

endmodule

// ==== testbench/lsuTb.sv ====
`timescale 1ns/1ns

module lsuTb import lsuPkg::*; ();

    logic              clk;
    logic              rst;
    logic              clr;
    logic              reqValid;
    lsOp_t             reqOp;
    logic [ADDR_W-1:0] reqAddr;
    logic [DATA_W-1:0] reqData;
    logic [TAG_W-1:0]  reqTag;
    logic              reqReady;
    logic              respValid;
    logic [DATA_W-1:0] respData;
    logic [TAG_W-1:0]  respTag;
    logic              respReady;

    int   respCount;
    int   mismatchCount;
    int   protocolCount;
    int   expectedTotal;
    logic sawFull;
    int   flowErrors = 0;
    int   sentExpected = 0;
    int   maxWait = 200;                // cycles per wait

    lsuTop dut_i (
        .clk       (clk),
        .rst       (rst),
        .clr       (clr),
        .reqValid  (reqValid),
        .reqOp     (reqOp),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .reqTag    (reqTag),
        .reqReady  (reqReady),
        .respValid (respValid),
        .respData  (respData),
        .respTag   (respTag),
        .respReady (respReady)
    );

    lsuChecker respChecker (
        .clk           (clk),
        .rst           (rst),
        .clr           (clr),
        .reqReady      (reqReady),
        .respValid     (respValid),
        .respReady     (respReady),
        .respData      (respData),
        .respTag       (respTag),
        .respCount     (respCount),
        .mismatchCount (mismatchCount),
        .protocolCount (protocolCount),
        .expectedTotal (expectedTotal),
        .sawFull       (sawFull)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // holds the request until the buffer takes it at the next rising edge
    task automatic sendReq(input logic [3:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] tag);
        int waited;
        @(negedge clk);
        reqValid = 1'b1;
        reqOp    = lsOp_t'(op);
        reqAddr  = addr;
        reqData  = data;
        reqTag   = tag;
        waited   = 0;
        while (!reqReady && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        if (!reqReady) begin
            flowErrors++;
            $display("request with tag %h was not accepted in time", tag);
        end
    endtask

    task automatic waitResponses(input int target);
        int waited;
        waited = 0;
        while (respCount < target && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        if (respCount < target) begin
            flowErrors++;
            $display("only %0d of %0d responses arrived in time", respCount, target);
        end
    endtask

    task automatic waitRespValid();
        int waited;
        waited = 0;
        while (!respValid && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        if (!respValid) begin
            flowErrors++;
            $display("respValid never rose while waiting for a response");
        end
    endtask

    // **************************************************
    // trace-driven stimulus
    // **************************************************
    initial begin
        int               fd;
        int               n;
        logic [8*160-1:0] line;
        logic [31:0]      kind;
        logic [31:0]      op;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      tag;
        logic [31:0]      expVal;
        logic [31:0]      flag;
        rst       = 1'b1;
        clr       = 1'b0;
        reqValid  = 1'b0;
        reqOp     = LB;
        reqAddr   = '0;
        reqData   = '0;
        reqTag    = '0;
        respReady = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("testbench/lsuTrace.txt", "r");
        if (fd == 0) begin
            flowErrors++;
            $display("could not open the trace file");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                kind, op, addr, data, tag, expVal, flag);
                    if (n == 7) begin
                        case (kind)
                            0: begin
                                sendReq(op[3:0], addr, data, tag[3:0]);
                                if (flag[0]) sentExpected++;
                            end
                            1: begin
                                @(negedge clk);
                                reqValid = 1'b0;
                                waitResponses(sentExpected);    // drain first
                                respReady = 1'b0;
                            end
                            2: begin
                                @(negedge clk);
                                reqValid = 1'b0;
                                if (sentExpected > respCount) begin
                                    waitRespValid();
                                    repeat (4) @(negedge clk);  // stall a while
                                end
                                respReady = 1'b1;
                            end
                            3: begin
                                @(negedge clk);
                                reqValid = 1'b0;
                                waitRespValid();
                                clr = 1'b1;
                                @(negedge clk);
                                clr = 1'b0;
                            end
                            default: begin
                                flowErrors++;
                                $display("unknown trace line kind %0h", kind);
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end

        @(negedge clk);
        reqValid  = 1'b0;
        respReady = 1'b1;
        waitResponses(expectedTotal);
        repeat (4) @(negedge clk);          // catch stray responses
        if (!sawFull) begin
            flowErrors++;
            $display("reqReady never dropped while responses were held");
        end

        $display("errors: mismatch %0d, protocol %0d, flow %0d",
                 mismatchCount, protocolCount, flowErrors);
        if (mismatchCount + protocolCount + flowErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== lsu.f ====
hw/lsuPkg.sv
hw/dataRam.sv
hw/memCtrl.sv
hw/loadStoreBuffer.sv
hw/dataAccess.sv
hw/lsuTop.sv
testbench/lsuChecker.sv
testbench/lsuTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module lsuTb -Mdir obj_dir -f lsu.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/VlsuTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// ==== testbench/lsuTrace.txt ====
# kind (0 request, 1 hold respReady, 2 release respReady, 3 clr) op addr data tag expData respFlag
# all hex; op 0 LB, 1 LH, 2 LW, 4 LBU, 5 LHU, 8 SB, 9 SH, A SW
0 A 00000010 DEADBEEF 1 00000000 1
0 2 00000010 00000000 2 DEADBEEF 1
0 A 00000020 12F4807F 3 00000000 1
0 0 00000020 00000000 4 0000007F 1
0 0 00000021 00000000 5 FFFFFF80 1
0 4 00000021 00000000 6 00000080 1
0 1 00000020 00000000 7 FFFF807F 1
0 5 00000020 00000000 8 0000807F 1
0 1 00000022 00000000 9 000012F4 1
0 8 00000011 123456AA A 00000000 1
0 9 00000012 FFFF5566 B 00000000 1
0 2 00000010 00000000 C 5566AAEF 1
1 0 00000000 00000000 0 00000000 0
0 2 00000010 00000000 D 5566AAEF 1
0 2 00000020 00000000 E 12F4807F 1
0 A 00000030 0BADF00D F 00000000 1
0 2 00000030 00000000 0 0BADF00D 1
0 5 00000012 00000000 1 00005566 1
2 0 00000000 00000000 0 00000000 0
1 0 00000000 00000000 0 00000000 0
0 2 00000010 00000000 2 5566AAEF 0
0 0 00000021 00000000 3 FFFFFF80 0
3 0 00000000 00000000 0 00000000 0
2 0 00000000 00000000 0 00000000 0
0 2 00000030 00000000 4 0BADF00D 1
0 A 000003FE A1B2C3D4 5 00000000 1
0 2 000003FE 00000000 6 A1B2C3D4 1
0 9 000007FF 00009988 7 00000000 1
0 2 FFFFFBFE 00000000 8 A19988D4 1
0 8 00000401 00000077 9 00000000 1
0 1 00000000 00000000 A 00007799 1
0 0 000003FF 00000000 B FFFFFF88 1
